//--- run_sim.sh
#!/bin/sh
# Build and run the multiply unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f src.f \
    --top-module tb_mult_unit \
    -o sim_mult_unit

./obj_dir/sim_mult_unit | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- sim/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o
);

    // Half of the 100 ns period
    localparam int HALF_PERIOD_NS = 50;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD_NS);
            clk_o = ~clk_o;
        end
    end

endmodule

//--- sim/tb_mult_unit.sv
`timescale 1ns/10ps

module tb_mult_unit;

    typedef logic [mult_pkg::XLEN-1:0]        word_t;
    typedef logic [mult_pkg::ROB_TAG_LEN-1:0] tag_t;

    // Accepted instructions in the main phase
    localparam int NUM_OPS         = 300;
    // 40 cycles per instruction plus reset and drain margin
    localparam int WATCHDOG_CYCLES = NUM_OPS * 40 + 400;
    localparam int DRAIN_CYCLES    = 200;

    logic          clk_i;
    logic          rst_n_i;
    logic          flush_i;
    logic          issue_valid_i;
    logic          issue_ready_o;
    mult_pkg::mult_op_t issue_op_i;
    word_t         issue_rs1_i;
    word_t         issue_rs2_i;
    tag_t          issue_tag_i;
    logic          cdb_valid_o;
    logic          cdb_ready_i;
    tag_t          cdb_tag_o;
    word_t         cdb_result_o;

    integer        seed;

    // Expected result per pending tag
    word_t         pending [tag_t];
    int            accepted;
    int            written;
    int            flushes;
    int            value_errs;
    int            proto_errs;
    logic          issue_taken;
    logic          after_flush;
    // Writeback payload seen during a stall
    logic          hold_valid;
    tag_t          hold_tag;
    word_t         hold_result;
    int            drain_cnt;

    tb_clock_gen u_clk (
        .clk_o (clk_i)
    );

    mult_unit DUT (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .issue_op_i    (issue_op_i),
        .issue_rs1_i   (issue_rs1_i),
        .issue_rs2_i   (issue_rs2_i),
        .issue_tag_i   (issue_tag_i),
        .cdb_valid_o   (cdb_valid_o),
        .cdb_ready_i   (cdb_ready_i),
        .cdb_tag_o     (cdb_tag_o),
        .cdb_result_o  (cdb_result_o)
    );

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Corner values mixed with random words
    function automatic word_t random_operand();
        word_t v;
        case (rand_below(10))
            0: v = '0;
            1: v = '1;
            2: v = {1'b1, {(mult_pkg::XLEN-1){1'b0}}};
            3: v = {1'b0, {(mult_pkg::XLEN-1){1'b1}}};
            // Most negative low word exercises the MULW sign
            4: v = {$random(seed), 32'h8000_0000};
            default: v = {$random(seed), $random(seed)};
        endcase
        return v;
    endfunction

    // Any tag not currently in flight
    function automatic tag_t free_tag();
        tag_t t;
        t = tag_t'(rand_below(1 << mult_pkg::ROB_TAG_LEN));
        while (pending.exists(t)) begin
            t = t + tag_t'(1);
        end
        return t;
    endfunction

    // Reference results from the opcode definitions in 128-bit modular arithmetic
    function automatic word_t expected_result(input mult_pkg::mult_op_t op,
                                              input word_t a, input word_t b);
        logic [2*mult_pkg::XLEN-1:0] sa;
        logic [2*mult_pkg::XLEN-1:0] za;
        logic [2*mult_pkg::XLEN-1:0] sb;
        logic [2*mult_pkg::XLEN-1:0] zb;
        logic [2*mult_pkg::XLEN-1:0] prod;
        logic [63:0]                 pw;
        word_t                       r;
        sa = {{mult_pkg::XLEN{a[mult_pkg::XLEN-1]}}, a};
        za = {{mult_pkg::XLEN{1'b0}}, a};
        sb = {{mult_pkg::XLEN{b[mult_pkg::XLEN-1]}}, b};
        zb = {{mult_pkg::XLEN{1'b0}}, b};
        pw = {32'd0, a[31:0]} * {32'd0, b[31:0]};
        case (op)
            mult_pkg::MULT_MULH:   prod = sa * sb;
            mult_pkg::MULT_MULHSU: prod = sa * zb;
            default:               prod = za * zb;
        endcase
        case (op)
            mult_pkg::MULT_MULH,
            mult_pkg::MULT_MULHU,
            mult_pkg::MULT_MULHSU: r = prod[2*mult_pkg::XLEN-1:mult_pkg::XLEN];
            mult_pkg::MULT_MULW:   r = {{(mult_pkg::XLEN-32){pw[31]}}, pw[31:0]};
            default:               r = prod[mult_pkg::XLEN-1:0];
        endcase
        return r;
    endfunction

    // Compare pre-edge DUT outputs against the model at one edge
    task automatic track_edge();
        issue_taken = 1'b0;
        if (flush_i) begin
            // This edge empties the DUT
            pending.delete();
            hold_valid  = 1'b0;
            after_flush = 1'b1;
        end else begin
            if (after_flush) begin
                assert (issue_ready_o) else begin
                    value_errs++;
                    $display("FAIL t=%0t issue_ready_o after flush: expected 1, got %0b",
                             $time, issue_ready_o);
                end
                assert (!cdb_valid_o) else begin
                    value_errs++;
                    $display("FAIL t=%0t cdb_valid_o after flush: expected 0, got %0b",
                             $time, cdb_valid_o);
                end
                after_flush = 1'b0;
            end
            assert (issue_ready_o == (pending.num() < mult_pkg::RS_DEPTH)) else begin
                value_errs++;
                $display("FAIL t=%0t issue_ready_o: expected %0b, got %0b", $time,
                         pending.num() < mult_pkg::RS_DEPTH, issue_ready_o);
            end
            // Payload must hold across a stalled cycle
            if (hold_valid) begin
                assert (cdb_valid_o) else begin
                    value_errs++;
                    $display("FAIL t=%0t cdb_valid_o during stall: expected 1, got %0b",
                             $time, cdb_valid_o);
                end
                assert (cdb_tag_o == hold_tag) else begin
                    value_errs++;
                    $display("FAIL t=%0t cdb_tag_o: expected %h, got %h", $time,
                             hold_tag, cdb_tag_o);
                end
                assert (cdb_result_o == hold_result) else begin
                    value_errs++;
                    $display("FAIL t=%0t cdb_result_o: expected %h, got %h", $time,
                             hold_result, cdb_result_o);
                end
            end
            hold_valid  = cdb_valid_o && !cdb_ready_i;
            hold_tag    = cdb_tag_o;
            hold_result = cdb_result_o;
            // Writeback transfer
            if (cdb_valid_o && cdb_ready_i) begin
                assert (pending.exists(cdb_tag_o)) else begin
                    proto_errs++;
                    $display("Writeback of tag %h that is not in flight at %0t",
                             cdb_tag_o, $time);
                end
                if (pending.exists(cdb_tag_o)) begin
                    assert (cdb_result_o == pending[cdb_tag_o]) else begin
                        value_errs++;
                        $display("FAIL t=%0t cdb_result_o: expected %h, got %h", $time,
                                 pending[cdb_tag_o], cdb_result_o);
                    end
                    pending.delete(cdb_tag_o);
                    written++;
                end
            end
            // Issue transfer
            if (issue_valid_i && issue_ready_o) begin
                pending[issue_tag_i] = expected_result(issue_op_i, issue_rs1_i, issue_rs2_i);
                accepted++;
                issue_taken = 1'b1;
            end
        end
    endtask

    // New stimulus for the next cycle
    task automatic drive_inputs(input logic draining);
        logic [2:0] op_sel;
        // A presented instruction stays until it is taken
        if (issue_taken || !issue_valid_i) begin
            if (!draining && accepted < NUM_OPS && rand_below(10) < 6) begin
                op_sel = 3'(rand_below(5));
                issue_valid_i <= 1'b1;
                issue_op_i    <= mult_pkg::mult_op_t'(op_sel);
                issue_rs1_i   <= random_operand();
                issue_rs2_i   <= random_operand();
                issue_tag_i   <= free_tag();
            end else begin
                issue_valid_i <= 1'b0;
            end
        end
        cdb_ready_i <= draining ? 1'b1 : (rand_below(10) < 7);
        // Rare single-cycle flush
        if (!draining && !flush_i && rand_below(100) == 0) begin
            flush_i <= 1'b1;
            flushes++;
        end else begin
            flush_i <= 1'b0;
        end
    endtask

    task automatic run_cycle(input logic draining);
        @(posedge clk_i);
        track_edge();
        drive_inputs(draining);
    endtask

    task automatic report_counts();
        $display("Errors: %0d value, %0d other (%0d accepted, %0d written back, %0d flushes)",
                 value_errs, proto_errs, accepted, written, flushes);
    endtask

    initial begin
        seed          = 73594;
        accepted      = 0;
        written       = 0;
        flushes       = 0;
        value_errs    = 0;
        proto_errs    = 0;
        issue_taken   = 1'b0;
        after_flush   = 1'b0;
        hold_valid    = 1'b0;
        rst_n_i       <= 1'b0;
        flush_i       <= 1'b0;
        issue_valid_i <= 1'b0;
        issue_op_i    <= mult_pkg::MULT_MUL;
        issue_rs1_i   <= '0;
        issue_rs2_i   <= '0;
        issue_tag_i   <= '0;
        cdb_ready_i   <= 1'b0;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        // State right after reset before any issue
        @(posedge clk_i);
        assert (!cdb_valid_o) else begin
            value_errs++;
            $display("FAIL t=%0t cdb_valid_o after reset: expected 0, got %0b",
                     $time, cdb_valid_o);
        end
        assert (issue_ready_o) else begin
            value_errs++;
            $display("FAIL t=%0t issue_ready_o after reset: expected 1, got %0b",
                     $time, issue_ready_o);
        end
        while (accepted < NUM_OPS) begin
            run_cycle(1'b0);
        end
        // Drain with the writeback port always ready
        drain_cnt = 0;
        while (pending.num() != 0 && drain_cnt < DRAIN_CYCLES) begin
            run_cycle(1'b1);
            drain_cnt++;
        end
        // A few idle cycles catch stray writebacks
        repeat (10) run_cycle(1'b1);
        assert (pending.num() == 0) else begin
            proto_errs++;
            $display("%0d accepted instructions were never written back", pending.num());
        end
        report_counts();
        if (value_errs == 0 && proto_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        report_counts();
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- src.f
src/mult_pkg.sv
src/eu_if.sv
src/mult_rs.sv
src/mult_eu.sv
src/mult_unit.sv
sim/tb_clock_gen.sv
sim/tb_mult_unit.sv

//--- src/eu_if.sv
`timescale 1ns/10ps

interface eu_if;

    // Operand side, RS to EU
    logic                             op_valid;
    logic                             op_ready;
    mult_pkg::mult_op_t               op_ctl;
    logic [mult_pkg::XLEN-1:0]        rs1;
    logic [mult_pkg::XLEN-1:0]        rs2;
    // Entry index travels with the operands
    logic [mult_pkg::RS_IDX_LEN-1:0]  op_idx;

    // Result side, EU to RS
    logic                             res_valid;
    logic                             res_ready;
    logic [mult_pkg::XLEN-1:0]        res_result;
    // Index of the entry that owns the result
    logic [mult_pkg::RS_IDX_LEN-1:0]  res_idx;

    // Reservation station view
    modport rs_mp (
        output op_valid, op_ctl, rs1, rs2, op_idx,
        input  op_ready,
        input  res_valid, res_result, res_idx,
        output res_ready
    );

    // Execution unit view
    modport eu_mp (
        input  op_valid, op_ctl, rs1, rs2, op_idx,
        output op_ready,
        output res_valid, res_result, res_idx,
        input  res_ready
    );

endinterface

//--- src/mult_eu.sv
`timescale 1ns/10ps

module mult_eu (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  flush_i,
    // Link to the reservation station
    eu_if.eu_mp   eu
);

    // Stage 1, full product
    logic                               s1_valid_q;
    mult_pkg::mult_op_t                 s1_op_q;
    logic [2*mult_pkg::XLEN-1:0]        s1_prod_q;
    logic [mult_pkg::RS_IDX_LEN-1:0]    s1_idx_q;

    // Stage 2, selected result
    logic                               s2_valid_q;
    logic [mult_pkg::XLEN-1:0]          s2_result_q;
    logic [mult_pkg::RS_IDX_LEN-1:0]    s2_idx_q;

    // Operands widened by one bit to cover both signed and unsigned forms
    logic signed [mult_pkg::XLEN:0]     a_ext;
    logic signed [mult_pkg::XLEN:0]     b_ext;
    logic [2*mult_pkg::XLEN-1:0]        prod_d;
    logic [mult_pkg::XLEN-1:0]          result_d;

    logic                               stall;

    // Operand extension per opcode
    always_comb begin
        case (eu.op_ctl)
            mult_pkg::MULT_MULH: begin
                a_ext = {eu.rs1[mult_pkg::XLEN-1], eu.rs1};
                b_ext = {eu.rs2[mult_pkg::XLEN-1], eu.rs2};
            end
            mult_pkg::MULT_MULHSU: begin
                a_ext = {eu.rs1[mult_pkg::XLEN-1], eu.rs1};
                b_ext = {1'b0, eu.rs2};
            end
            mult_pkg::MULT_MULW: begin
                // Only the low words take part
                a_ext = {{(mult_pkg::XLEN - 31){1'b0}}, eu.rs1[31:0]};
                b_ext = {{(mult_pkg::XLEN - 31){1'b0}}, eu.rs2[31:0]};
            end
            default: begin
                // MUL and MULHU, sign has no effect on the low half
                a_ext = {1'b0, eu.rs1};
                b_ext = {1'b0, eu.rs2};
            end
        endcase
    end

    // 128 bits hold every product form exactly
    assign prod_d = a_ext * b_ext;

    // Half select and word sign extension
    always_comb begin
        case (s1_op_q)
            mult_pkg::MULT_MULH,
            mult_pkg::MULT_MULHU,
            mult_pkg::MULT_MULHSU: result_d = s1_prod_q[2*mult_pkg::XLEN-1:mult_pkg::XLEN];
            mult_pkg::MULT_MULW:   result_d = {{(mult_pkg::XLEN - 32){s1_prod_q[31]}},
                                               s1_prod_q[31:0]};
            default:               result_d = s1_prod_q[mult_pkg::XLEN-1:0];
        endcase
    end

    // Whole pipe freezes when the output is not taken
    assign stall       = s2_valid_q & ~eu.res_ready;
    assign eu.op_ready = ~s1_valid_q | ~stall;

    assign eu.res_valid  = s2_valid_q;
    assign eu.res_result = s2_result_q;
    assign eu.res_idx    = s2_idx_q;

    // Stage valid bits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (eu.op_ready) begin
                s1_valid_q <= eu.op_valid;
            end
            if (!stall) begin
                s2_valid_q <= s1_valid_q;
            end
        end
    end

    // Stage payloads
    always_ff @(posedge clk_i) begin
        if (eu.op_valid && eu.op_ready) begin
            s1_op_q   <= eu.op_ctl;
            s1_prod_q <= prod_d;
            s1_idx_q  <= eu.op_idx;
        end
        if (!stall && s1_valid_q) begin
            s2_result_q <= result_d;
            s2_idx_q    <= s1_idx_q;
        end
    end

endmodule

//--- src/mult_pkg.sv
package mult_pkg;

    // Operand and result width
    localparam int XLEN = 64;

    // Reorder-buffer tag width
    localparam int ROB_TAG_LEN = 4;

    // Reservation station entries
    localparam int RS_DEPTH = 4;

    // Entry index width
    localparam int RS_IDX_LEN = $clog2(RS_DEPTH);

    // Multiply opcodes
    typedef enum logic [2:0] {
        // Low half of the product
        MULT_MUL    = 3'd0,
        // High half, signed x signed
        MULT_MULH   = 3'd1,
        // High half, unsigned x unsigned
        MULT_MULHU  = 3'd2,
        // High half, rs1 signed x rs2 unsigned
        MULT_MULHSU = 3'd3,
        // 32-bit product, sign-extended to XLEN
        MULT_MULW   = 3'd4
    } mult_op_t;

    // Reservation station entry state
    typedef enum logic [1:0] {
        // Free slot
        RS_EMPTY   = 2'd0,
        // Operands stored, not yet sent to the unit
        RS_WAIT_EX = 2'd1,
        // In flight inside the multiplier
        RS_EXEC    = 2'd2,
        // Result stored, waiting for the CDB
        RS_DONE    = 2'd3
    } rs_state_t;

endpackage

//--- src/mult_rs.sv
`timescale 1ns/10ps

module mult_rs (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               flush_i,
    // Issue from dispatch
    input  logic                               issue_valid_i,
    output logic                               issue_ready_o,
    input  mult_pkg::mult_op_t                 issue_op_i,
    input  logic [mult_pkg::XLEN-1:0]          issue_rs1_i,
    input  logic [mult_pkg::XLEN-1:0]          issue_rs2_i,
    input  logic [mult_pkg::ROB_TAG_LEN-1:0]   issue_tag_i,
    // Writeback to the CDB
    output logic                               cdb_valid_o,
    input  logic                               cdb_ready_i,
    output logic [mult_pkg::ROB_TAG_LEN-1:0]   cdb_tag_o,
    output logic [mult_pkg::XLEN-1:0]          cdb_result_o,
    // Execution unit link
    eu_if.rs_mp                                eu
);

    // Per-entry storage
    mult_pkg::rs_state_t                state_q  [mult_pkg::RS_DEPTH];
    mult_pkg::mult_op_t                 op_q     [mult_pkg::RS_DEPTH];
    logic [mult_pkg::XLEN-1:0]          rs1_q    [mult_pkg::RS_DEPTH];
    logic [mult_pkg::XLEN-1:0]          rs2_q    [mult_pkg::RS_DEPTH];
    logic [mult_pkg::ROB_TAG_LEN-1:0]   tag_q    [mult_pkg::RS_DEPTH];
    logic [mult_pkg::XLEN-1:0]          result_q [mult_pkg::RS_DEPTH];

    // Selection results
    logic                               empty_found;
    logic [mult_pkg::RS_IDX_LEN-1:0]    empty_idx;
    logic                               wait_found;
    logic [mult_pkg::RS_IDX_LEN-1:0]    wait_idx;
    logic                               done_found;
    logic [mult_pkg::RS_IDX_LEN-1:0]    done_idx;

    // Dispatch hold while the unit stalls
    logic                               disp_lock_q;
    logic [mult_pkg::RS_IDX_LEN-1:0]    disp_lock_idx_q;
    logic [mult_pkg::RS_IDX_LEN-1:0]    disp_idx;

    // Entry currently on the CDB
    logic [mult_pkg::RS_IDX_LEN-1:0]    wb_idx_q;

    logic                               issue_fire;
    logic                               disp_fire;
    logic                               cdb_fire;
    logic                               wb_load;

    // Lowest-index search, scanning downward so the lowest match wins
    always_comb begin
        empty_found = 1'b0;
        empty_idx   = '0;
        wait_found  = 1'b0;
        wait_idx    = '0;
        done_found  = 1'b0;
        done_idx    = '0;
        for (int i = mult_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            if (state_q[i] == mult_pkg::RS_EMPTY) begin
                empty_found = 1'b1;
                empty_idx   = i[mult_pkg::RS_IDX_LEN-1:0];
            end
            if (state_q[i] == mult_pkg::RS_WAIT_EX) begin
                wait_found = 1'b1;
                wait_idx   = i[mult_pkg::RS_IDX_LEN-1:0];
            end
            if (state_q[i] == mult_pkg::RS_DONE) begin
                done_found = 1'b1;
                done_idx   = i[mult_pkg::RS_IDX_LEN-1:0];
            end
        end
    end

    assign issue_ready_o = empty_found;
    assign issue_fire    = issue_valid_i & empty_found;

    // Keep the same entry on the bus until the unit takes it
    assign disp_idx    = disp_lock_q ? disp_lock_idx_q : wait_idx;
    assign eu.op_valid = disp_lock_q | wait_found;
    assign eu.op_ctl   = op_q[disp_idx];
    assign eu.rs1      = rs1_q[disp_idx];
    assign eu.rs2      = rs2_q[disp_idx];
    assign eu.op_idx   = disp_idx;
    assign disp_fire   = eu.op_valid & eu.op_ready;

    // Results are always accepted, each has its own entry
    assign eu.res_ready = 1'b1;

    assign cdb_fire = cdb_valid_o & cdb_ready_i;
    assign wb_load  = ~cdb_valid_o & done_found;

    // Entry state and writeback control
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < mult_pkg::RS_DEPTH; i++) begin
                state_q[i] <= mult_pkg::RS_EMPTY;
            end
            cdb_valid_o     <= 1'b0;
            wb_idx_q        <= '0;
            disp_lock_q     <= 1'b0;
            disp_lock_idx_q <= '0;
        end else if (flush_i) begin
            for (int i = 0; i < mult_pkg::RS_DEPTH; i++) begin
                state_q[i] <= mult_pkg::RS_EMPTY;
            end
            cdb_valid_o <= 1'b0;
            disp_lock_q <= 1'b0;
        end else begin
            // The four updates always hit entries in different states
            if (issue_fire) begin
                state_q[empty_idx] <= mult_pkg::RS_WAIT_EX;
            end
            if (disp_fire) begin
                state_q[disp_idx] <= mult_pkg::RS_EXEC;
            end
            if (eu.res_valid) begin
                state_q[eu.res_idx] <= mult_pkg::RS_DONE;
            end
            if (cdb_fire) begin
                // Transfer done, slot is free again
                state_q[wb_idx_q] <= mult_pkg::RS_EMPTY;
                cdb_valid_o       <= 1'b0;
            end else if (wb_load) begin
                cdb_valid_o <= 1'b1;
                wb_idx_q    <= done_idx;
            end
            disp_lock_q     <= eu.op_valid & ~eu.op_ready;
            disp_lock_idx_q <= disp_idx;
        end
    end

    // Payload storage
    always_ff @(posedge clk_i) begin
        if (issue_fire) begin
            op_q[empty_idx]  <= issue_op_i;
            rs1_q[empty_idx] <= issue_rs1_i;
            rs2_q[empty_idx] <= issue_rs2_i;
            tag_q[empty_idx] <= issue_tag_i;
        end
        if (eu.res_valid) begin
            result_q[eu.res_idx] <= eu.res_result;
        end
        // CDB payload only changes while the port is idle
        if (wb_load) begin
            cdb_tag_o    <= tag_q[done_idx];
            cdb_result_o <= result_q[done_idx];
        end
    end

endmodule

//--- src/mult_unit.sv
`timescale 1ns/10ps

module mult_unit (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    // Single-cycle clear of all in-flight work
    input  logic                               flush_i,
    // Issue port
    input  logic                               issue_valid_i,
    output logic                               issue_ready_o,
    input  mult_pkg::mult_op_t                 issue_op_i,
    input  logic [mult_pkg::XLEN-1:0]          issue_rs1_i,
    input  logic [mult_pkg::XLEN-1:0]          issue_rs2_i,
    input  logic [mult_pkg::ROB_TAG_LEN-1:0]   issue_tag_i,
    // Writeback port
    output logic                               cdb_valid_o,
    input  logic                               cdb_ready_i,
    output logic [mult_pkg::ROB_TAG_LEN-1:0]   cdb_tag_o,
    output logic [mult_pkg::XLEN-1:0]          cdb_result_o
);

    // RS to EU link
    eu_if eu_bus ();

    // Reservation station
    mult_rs u_rs (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .issue_op_i    (issue_op_i),
        .issue_rs1_i   (issue_rs1_i),
        .issue_rs2_i   (issue_rs2_i),
        .issue_tag_i   (issue_tag_i),
        .cdb_valid_o   (cdb_valid_o),
        .cdb_ready_i   (cdb_ready_i),
        .cdb_tag_o     (cdb_tag_o),
        .cdb_result_o  (cdb_result_o),
        .eu            (eu_bus.rs_mp)
    );

    // Two-stage multiplier
    mult_eu u_eu (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .eu      (eu_bus.eu_mp)
    );

endmodule
